/* verilog/reindeer_pkg.sv */
// reindeer core shared definitions
// widths, opcodes, ALU codes and controller states
package reindeer_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] pc_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;

    // {funct7[5], funct3}
    typedef logic [3:0]      alu_op_t;

    // ----------------------------------------------------------------------
    // opcodes of the supported instruction groups
    // ----------------------------------------------------------------------
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // ----------------------------------------------------------------------
    // ALU operations
    // ----------------------------------------------------------------------
    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SUB  = 4'b1000;
    localparam alu_op_t ALU_SLL  = 4'b0001;
    localparam alu_op_t ALU_SLT  = 4'b0010;
    localparam alu_op_t ALU_SLTU = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_SRA  = 4'b1101;
    localparam alu_op_t ALU_OR   = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        PAUSED
    } ctrl_state_e;

endpackage

/* verilog/reindeer_fetch.sv */
// reindeer instruction fetch
// keeps the PC, requests the next word and latches the returned instruction
`timescale 1ns/1ns

module reindeer_fetch #(
    parameter int MEM_ADDR_BITS = 14
) (
    input  logic                       clk,
    input  logic                       rst_i,

    input  logic                       fetch_init_i,
    input  reindeer_pkg::pc_t          start_address_i,
    input  logic                       fetch_next_i,
    input  logic                       advance_i,

    input  reindeer_pkg::inst_t        mem_read_data_i,
    input  logic                       mem_read_ack_i,

    output logic [MEM_ADDR_BITS-1:0]   mem_addr_o,
    output logic                       mem_read_en_o,

    output reindeer_pkg::pc_t          pc_o,
    output reindeer_pkg::inst_t        ir_o
);

    reindeer_pkg::pc_t pc;

    // word address, held while the read is outstanding
    assign mem_addr_o = pc[MEM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc            <= '0;
            mem_read_en_o <= 1'b0;
        end else begin
            // request goes out the cycle after the PC settles
            mem_read_en_o <= fetch_init_i | fetch_next_i;
            if (fetch_init_i) begin
                pc <= start_address_i;
            end else if (advance_i) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // instruction and its address, also seen on the peek outputs
    always_ff @(posedge clk) begin
        if (mem_read_ack_i) begin
            ir_o <= mem_read_data_i;
            pc_o <= pc;
        end
    end

endmodule

/* verilog/reindeer_decode.sv */
// reindeer instruction decode
// splits the instruction word, builds immediates and classifies the operation
`timescale 1ns/1ns

module reindeer_decode (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       decode_enable_i,
    input  reindeer_pkg::inst_t        ir_i,

    output reindeer_pkg::reg_addr_t    rs1_o,
    output reindeer_pkg::reg_addr_t    rs2_o,
    output reindeer_pkg::reg_addr_t    rd_o,
    output reindeer_pkg::word_t        imm_o,
    output reindeer_pkg::alu_op_t      alu_op_o,
    output logic                       use_imm_o,
    output logic                       is_lui_o,
    output logic                       is_auipc_o,
    output logic                       halt_o
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    reindeer_pkg::word_t imm_i_type;
    reindeer_pkg::word_t imm_u_type;
    logic                is_upper;
    logic                alt_bit;
    logic                halt_next;

    assign opcode = ir_i[6:0];
    assign funct3 = ir_i[14:12];
    assign funct7 = ir_i[31:25];

    // register file reads during DECODE, so no register here
    assign rs1_o = ir_i[19:15];
    assign rs2_o = ir_i[24:20];

    assign imm_i_type = {{20{ir_i[31]}}, ir_i[31:20]};
    assign imm_u_type = {ir_i[31:12], 12'b0};
    assign is_upper   = (opcode == reindeer_pkg::OPCODE_LUI) ||
                        (opcode == reindeer_pkg::OPCODE_AUIPC);

    always_comb begin
        alt_bit   = 1'b0;
        halt_next = 1'b1;
        case (opcode)
            reindeer_pkg::OPCODE_OP: begin
                alt_bit = funct7[5];
                // SUB and SRA only; M extension and stray bits pause
                if (funct7 == 7'h20) begin
                    halt_next = !((funct3 == 3'b000) || (funct3 == 3'b101));
                end else begin
                    halt_next = (funct7 != 7'h00);
                end
            end
            reindeer_pkg::OPCODE_OP_IMM: begin
                // bit 30 of the immediate only selects SRAI
                alt_bit   = (funct3 == 3'b101) && funct7[5];
                halt_next = 1'b0;
            end
            reindeer_pkg::OPCODE_LUI, reindeer_pkg::OPCODE_AUIPC: begin
                halt_next = 1'b0;
            end
            // EBREAK, and any other system instruction
            reindeer_pkg::OPCODE_SYSTEM: halt_next = 1'b1;
            default: halt_next = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            use_imm_o  <= 1'b0;
            is_lui_o   <= 1'b0;
            is_auipc_o <= 1'b0;
            halt_o     <= 1'b0;
        end else if (decode_enable_i) begin
            use_imm_o  <= (opcode == reindeer_pkg::OPCODE_OP_IMM);
            is_lui_o   <= (opcode == reindeer_pkg::OPCODE_LUI);
            is_auipc_o <= (opcode == reindeer_pkg::OPCODE_AUIPC);
            halt_o     <= halt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_enable_i) begin
            rd_o     <= ir_i[11:7];
            imm_o    <= is_upper ? imm_u_type : imm_i_type;
            alu_op_o <= {alt_bit, funct3};
        end
    end

endmodule

/* verilog/reindeer_reg_file.sv */
// reindeer register file
// 31 writable registers plus a hardwired x0, debugger access while paused
`timescale 1ns/1ns

module reindeer_reg_file (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       paused_i,

    input  reindeer_pkg::reg_addr_t    rs1_addr_i,
    input  reindeer_pkg::reg_addr_t    rs2_addr_i,
    input  logic                       write_en_i,
    input  reindeer_pkg::reg_addr_t    write_addr_i,
    input  reindeer_pkg::word_t        write_data_i,

    input  logic                       ocd_reg_we_i,
    input  reindeer_pkg::reg_addr_t    ocd_reg_write_addr_i,
    input  reindeer_pkg::word_t        ocd_reg_write_data_i,
    input  reindeer_pkg::reg_addr_t    ocd_reg_read_addr_i,

    output reindeer_pkg::word_t        rs1_data_o,
    output reindeer_pkg::word_t        rs2_data_o
);

    reindeer_pkg::word_t     regs [1:31];
    reindeer_pkg::reg_addr_t rs2_addr;
    reindeer_pkg::reg_addr_t wr_addr;
    reindeer_pkg::word_t     wr_data;
    logic                    wr_en;

    // debugger owns the rs2 port and the write port while paused
    assign rs2_addr = paused_i ? ocd_reg_read_addr_i  : rs2_addr_i;
    assign wr_en    = paused_i ? ocd_reg_we_i         : write_en_i;
    assign wr_addr  = paused_i ? ocd_reg_write_addr_i : write_addr_i;
    assign wr_data  = paused_i ? ocd_reg_write_data_i : write_data_i;

    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rs1_data_o <= '0;
            rs2_data_o <= '0;
        end else begin
            rs1_data_o <= (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
            rs2_data_o <= (rs2_addr == '0) ? '0 : regs[rs2_addr];
        end
    end

endmodule

/* verilog/reindeer_execute.sv */
// reindeer execute stage
// integer ALU and upper-immediate results, drives the register write-back
`timescale 1ns/1ns

module reindeer_execute (
    input  logic                       exe_enable_i,
    input  logic                       halt_i,
    input  reindeer_pkg::alu_op_t      alu_op_i,
    input  logic                       use_imm_i,
    input  logic                       is_lui_i,
    input  logic                       is_auipc_i,
    input  reindeer_pkg::word_t        rs1_data_i,
    input  reindeer_pkg::word_t        rs2_data_i,
    input  reindeer_pkg::word_t        imm_i,
    input  reindeer_pkg::pc_t          pc_i,
    input  reindeer_pkg::reg_addr_t    rd_i,

    output logic                       write_en_o,
    output reindeer_pkg::reg_addr_t    write_addr_o,
    output reindeer_pkg::word_t        write_data_o
);

    reindeer_pkg::word_t operand_b;
    reindeer_pkg::word_t alu_result;
    logic [4:0]          shamt;

    assign operand_b = use_imm_i ? imm_i : rs2_data_i;
    // shift amount from the low five bits, also for SLLI/SRLI/SRAI
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (alu_op_i)
            reindeer_pkg::ALU_ADD:  alu_result = rs1_data_i + operand_b;
            reindeer_pkg::ALU_SUB:  alu_result = rs1_data_i - operand_b;
            reindeer_pkg::ALU_SLL:  alu_result = rs1_data_i << shamt;
            reindeer_pkg::ALU_SLT: begin
                alu_result = {31'b0, $signed(rs1_data_i) < $signed(operand_b)};
            end
            reindeer_pkg::ALU_SLTU: alu_result = {31'b0, rs1_data_i < operand_b};
            reindeer_pkg::ALU_XOR:  alu_result = rs1_data_i ^ operand_b;
            reindeer_pkg::ALU_SRL:  alu_result = rs1_data_i >> shamt;
            reindeer_pkg::ALU_SRA: begin
                alu_result = reindeer_pkg::word_t'($signed(rs1_data_i) >>> shamt);
            end
            reindeer_pkg::ALU_OR:   alu_result = rs1_data_i | operand_b;
            reindeer_pkg::ALU_AND:  alu_result = rs1_data_i & operand_b;
            default:                alu_result = rs1_data_i + operand_b;
        endcase
    end

    // ----------------------------------------------------------------------
    // write-back
    // ----------------------------------------------------------------------
    always_comb begin
        if (is_lui_i) begin
            write_data_o = imm_i;
        end else if (is_auipc_i) begin
            write_data_o = pc_i + imm_i;
        end else begin
            write_data_o = alu_result;
        end
    end

    // a halted instruction leaves registers and PC untouched
    assign write_en_o   = exe_enable_i & ~halt_i;
    assign write_addr_o = rd_i;

endmodule

/* verilog/reindeer_controller.sv */
// reindeer controller
// sequences start, fetch, decode, execute and the paused state
`timescale 1ns/1ns

module reindeer_controller (
    input  logic clk,
    input  logic rst_i,
    input  logic start_i,
    input  logic mem_read_ack_i,
    input  logic halt_i,

    output logic fetch_init_o,
    output logic fetch_next_o,
    output logic decode_enable_o,
    output logic exe_enable_o,
    output logic paused_o
);

    reindeer_pkg::ctrl_state_e state;
    reindeer_pkg::ctrl_state_e state_next;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= reindeer_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next   = state;
        fetch_init_o = 1'b0;
        fetch_next_o = 1'b0;
        case (state)
            reindeer_pkg::IDLE, reindeer_pkg::PAUSED: begin
                if (start_i) begin
                    fetch_init_o = 1'b1;
                    state_next   = reindeer_pkg::FETCH;
                end
            end
            // memory latency is variable, wait for the ack
            reindeer_pkg::FETCH: begin
                if (mem_read_ack_i) begin
                    state_next = reindeer_pkg::DECODE;
                end
            end
            reindeer_pkg::DECODE: state_next = reindeer_pkg::EXECUTE;
            reindeer_pkg::EXECUTE: begin
                if (halt_i) begin
                    state_next = reindeer_pkg::PAUSED;
                end else begin
                    fetch_next_o = 1'b1;
                    state_next   = reindeer_pkg::FETCH;
                end
            end
            default: state_next = reindeer_pkg::IDLE;
        endcase
    end

    assign decode_enable_o = (state == reindeer_pkg::DECODE);
    assign exe_enable_o    = (state == reindeer_pkg::EXECUTE);
    assign paused_o        = (state == reindeer_pkg::IDLE) || (state == reindeer_pkg::PAUSED);

endmodule

/* verilog/reindeer_core.sv */
// reindeer RV32I core top level
// multi-cycle integer core, one instruction at a time, with debugger register access
`timescale 1ns/1ns

module reindeer_core #(
    parameter int MEM_ADDR_BITS = 14
) (
    input  logic                       clk,
    input  logic                       rst_i,

    input  logic                       start_i,
    input  reindeer_pkg::pc_t          start_address_i,

    output logic [MEM_ADDR_BITS-1:0]   mem_addr_o,
    output logic                       mem_read_en_o,
    input  reindeer_pkg::inst_t        mem_read_data_i,
    input  logic                       mem_read_ack_i,

    input  logic                       ocd_reg_we_i,
    input  reindeer_pkg::reg_addr_t    ocd_reg_write_addr_i,
    input  reindeer_pkg::word_t        ocd_reg_write_data_i,
    input  reindeer_pkg::reg_addr_t    ocd_reg_read_addr_i,
    output reindeer_pkg::word_t        ocd_reg_data_o,

    output logic                       paused_o,
    output reindeer_pkg::pc_t          peek_pc_o,
    output reindeer_pkg::inst_t        peek_ir_o
);

    logic                    fetch_init;
    logic                    fetch_next;
    logic                    decode_enable;
    logic                    exe_enable;
    logic                    paused;
    reindeer_pkg::pc_t       pc;
    reindeer_pkg::inst_t     ir;

    reindeer_pkg::reg_addr_t rs1;
    reindeer_pkg::reg_addr_t rs2;
    reindeer_pkg::reg_addr_t rd;
    reindeer_pkg::word_t     imm;
    reindeer_pkg::alu_op_t   alu_op;
    logic                    use_imm;
    logic                    is_lui;
    logic                    is_auipc;
    logic                    halt;

    reindeer_pkg::word_t     rs1_data;
    reindeer_pkg::word_t     rs2_data;
    logic                    write_en;
    reindeer_pkg::reg_addr_t write_addr;
    reindeer_pkg::word_t     write_data;

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------
    reindeer_controller controller_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .start_i         (start_i),
        .mem_read_ack_i  (mem_read_ack_i),
        .halt_i          (halt),
        .fetch_init_o    (fetch_init),
        .fetch_next_o    (fetch_next),
        .decode_enable_o (decode_enable),
        .exe_enable_o    (exe_enable),
        .paused_o        (paused)
    );

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------
    // PC only moves when execute writes back
    reindeer_fetch #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) fetch_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .fetch_init_i    (fetch_init),
        .start_address_i (start_address_i),
        .fetch_next_i    (fetch_next),
        .advance_i       (write_en),
        .mem_read_data_i (mem_read_data_i),
        .mem_read_ack_i  (mem_read_ack_i),
        .mem_addr_o      (mem_addr_o),
        .mem_read_en_o   (mem_read_en_o),
        .pc_o            (pc),
        .ir_o            (ir)
    );

    reindeer_decode decode_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .decode_enable_i (decode_enable),
        .ir_i            (ir),
        .rs1_o           (rs1),
        .rs2_o           (rs2),
        .rd_o            (rd),
        .imm_o           (imm),
        .alu_op_o        (alu_op),
        .use_imm_o       (use_imm),
        .is_lui_o        (is_lui),
        .is_auipc_o      (is_auipc),
        .halt_o          (halt)
    );

    reindeer_reg_file reg_file_i (
        .clk                  (clk),
        .rst_i                (rst_i),
        .paused_i             (paused),
        .rs1_addr_i           (rs1),
        .rs2_addr_i           (rs2),
        .write_en_i           (write_en),
        .write_addr_i         (write_addr),
        .write_data_i         (write_data),
        .ocd_reg_we_i         (ocd_reg_we_i),
        .ocd_reg_write_addr_i (ocd_reg_write_addr_i),
        .ocd_reg_write_data_i (ocd_reg_write_data_i),
        .ocd_reg_read_addr_i  (ocd_reg_read_addr_i),
        .rs1_data_o           (rs1_data),
        .rs2_data_o           (rs2_data)
    );

    reindeer_execute execute_i (
        .exe_enable_i (exe_enable),
        .halt_i       (halt),
        .alu_op_i     (alu_op),
        .use_imm_i    (use_imm),
        .is_lui_i     (is_lui),
        .is_auipc_i   (is_auipc),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .imm_i        (imm),
        .pc_i         (pc),
        .rd_i         (rd),
        .write_en_o   (write_en),
        .write_addr_o (write_addr),
        .write_data_o (write_data)
    );

    // debugger reads share the rs2 port
    assign ocd_reg_data_o = rs2_data;
    assign paused_o       = paused;
    assign peek_pc_o      = pc;
    assign peek_ir_o      = ir;

endmodule

/* verification/reindeer_assertions.sv */
// reindeer memory read protocol checks
// bound to the core, watches requests, acknowledges and the controller state
`timescale 1ns/1ns

module reindeer_assertions #(
    parameter int MEM_ADDR_BITS = 14
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       paused_i,
    input  logic                       mem_read_en_i,
    input  logic                       mem_read_ack_i,
    input  logic [MEM_ADDR_BITS-1:0]   mem_addr_i,
    input  reindeer_pkg::ctrl_state_e  state_i
);

    int   failures = 0;
    logic outstanding;

    // high from the cycle after a request until the cycle after its ack
    always_ff @(posedge clk) begin
        if (rst_i) begin
            outstanding <= 1'b0;
        end else if (mem_read_en_i) begin
            outstanding <= 1'b1;
        end else if (mem_read_ack_i) begin
            outstanding <= 1'b0;
        end
    end

    no_request_while_paused: assert property (
        @(posedge clk) disable iff (rst_i) paused_i |-> !mem_read_en_i
    ) else begin
        failures++;
        $error("memory read requested while paused");
    end

    single_outstanding_request: assert property (
        @(posedge clk) disable iff (rst_i) mem_read_en_i |-> !outstanding
    ) else begin
        failures++;
        $error("second memory read requested before the acknowledge");
    end

    address_held: assert property (
        @(posedge clk) disable iff (rst_i) outstanding |-> $stable(mem_addr_i)
    ) else begin
        failures++;
        $error("memory address changed while a read was outstanding");
    end

    request_in_fetch: assert property (
        @(posedge clk) disable iff (rst_i)
        mem_read_en_i |-> (state_i == reindeer_pkg::FETCH)
    ) else begin
        failures++;
        $error("memory read requested outside the FETCH state");
    end

endmodule

/* verification/reindeer_tb.sv */
// reindeer core testbench
// random programs checked against an instruction-set model, debugger access included
`timescale 1ns/1ns

module reindeer_tb;

    localparam int MEM_ADDR_BITS = 14;
    localparam int N_PROGS       = 20;
    localparam int MAX_LEN       = 40;
    localparam int MAX_CYCLES    = N_PROGS * MAX_LEN * 8 + N_PROGS * 100 + 1000;

    // RV32I encodings
    localparam logic [6:0]          OP_OP     = 7'b0110011;
    localparam logic [6:0]          OP_IMM    = 7'b0010011;
    localparam logic [6:0]          OP_LUI    = 7'b0110111;
    localparam logic [6:0]          OP_AUIPC  = 7'b0010111;
    localparam reindeer_pkg::inst_t EBREAK    = 32'h0010_0073;

    logic                       clk = 1'b0;
    logic                       rst_i;
    logic                       start_i;
    reindeer_pkg::pc_t          start_address_i;
    logic [MEM_ADDR_BITS-1:0]   mem_addr_o;
    logic                       mem_read_en_o;
    reindeer_pkg::inst_t        mem_read_data_i;
    logic                       mem_read_ack_i;
    logic                       ocd_reg_we_i;
    reindeer_pkg::reg_addr_t    ocd_reg_write_addr_i;
    reindeer_pkg::word_t        ocd_reg_write_data_i;
    reindeer_pkg::reg_addr_t    ocd_reg_read_addr_i;
    reindeer_pkg::word_t        ocd_reg_data_o;
    logic                       paused_o;
    reindeer_pkg::pc_t          peek_pc_o;
    reindeer_pkg::inst_t        peek_ir_o;

    reindeer_pkg::inst_t        prog [0:MAX_LEN-1];
    reindeer_pkg::word_t        model_regs [0:31];
    reindeer_pkg::pc_t          start_pc = '0;
    int                         prog_len = 0;
    int                         fetch_idx = 0;
    int                         cycles = 0;
    logic [31:0]                stim_rng = 32'd53;
    logic [31:0]                mem_rng = 32'd53;

    reindeer_core #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) uut (
        .clk                  (clk),
        .rst_i                (rst_i),
        .start_i              (start_i),
        .start_address_i      (start_address_i),
        .mem_addr_o           (mem_addr_o),
        .mem_read_en_o        (mem_read_en_o),
        .mem_read_data_i      (mem_read_data_i),
        .mem_read_ack_i       (mem_read_ack_i),
        .ocd_reg_we_i         (ocd_reg_we_i),
        .ocd_reg_write_addr_i (ocd_reg_write_addr_i),
        .ocd_reg_write_data_i (ocd_reg_write_data_i),
        .ocd_reg_read_addr_i  (ocd_reg_read_addr_i),
        .ocd_reg_data_o       (ocd_reg_data_o),
        .paused_o             (paused_o),
        .peek_pc_o            (peek_pc_o),
        .peek_ir_o            (peek_ir_o)
    );

    bind reindeer_core reindeer_assertions #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) assertions_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .paused_i       (paused_o),
        .mem_read_en_i  (mem_read_en_o),
        .mem_read_ack_i (mem_read_ack_i),
        .mem_addr_i     (mem_addr_o),
        .state_i        (controller_i.state)
    );

    always #4 clk = ~clk;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] stim_random();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input reindeer_pkg::word_t expected,
                              input reindeer_pkg::word_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %08h actual %08h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_pc(input string name, input reindeer_pkg::pc_t expected,
                            input reindeer_pkg::pc_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %08h actual %08h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_inst(input string name, input reindeer_pkg::inst_t expected,
                              input reindeer_pkg::inst_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %08h actual %08h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic reg_write(input reindeer_pkg::reg_addr_t addr,
                             input reindeer_pkg::word_t data);
        ocd_reg_we_i         = 1'b1;
        ocd_reg_write_addr_i = addr;
        ocd_reg_write_data_i = data;
        wait_cycle();
        ocd_reg_we_i         = 1'b0;
    endtask

    // read data shows up one cycle after the address
    task automatic compare_all_regs();
        int r;
        for (r = 0; r < 32; r++) begin
            ocd_reg_read_addr_i = reindeer_pkg::reg_addr_t'(r);
            wait_cycle();
            check_word($sformatf("ocd_reg_data_o[x%0d]", r), model_regs[r], ocd_reg_data_o);
        end
    endtask

    // ----------------------------------------------------------------------
    // instruction-set model
    // ----------------------------------------------------------------------
    function automatic reindeer_pkg::word_t expected_result(input reindeer_pkg::inst_t ir,
            input reindeer_pkg::pc_t pc, input reindeer_pkg::word_t a,
            input reindeer_pkg::word_t rs2_val);
        reindeer_pkg::word_t b;
        logic                alt;
        logic [2:0]          f3;
        f3 = ir[14:12];
        case (ir[6:0])
            OP_LUI:   return {ir[31:12], 12'h000};
            OP_AUIPC: return pc + {ir[31:12], 12'h000};
            OP_IMM: begin
                b   = {{20{ir[31]}}, ir[31:20]};
                alt = (f3 == 3'd5) && ir[30];
            end
            default: begin
                b   = rs2_val;
                alt = ir[30];
            end
        endcase
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? reindeer_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model();
        reindeer_pkg::inst_t ir;
        reindeer_pkg::word_t result;
        int                  i;
        // last word is EBREAK, which writes nothing
        for (i = 0; i < prog_len - 1; i++) begin
            ir     = prog[i];
            result = expected_result(ir, start_pc + reindeer_pkg::pc_t'(4 * i),
                                     model_regs[ir[19:15]], model_regs[ir[24:20]]);
            if (ir[11:7] != 5'd0) begin
                model_regs[ir[11:7]] = result;
            end
        end
    endtask

    // kind 0 OP, kind 1 OP-IMM, kind 2 LUI/AUIPC
    task automatic make_program(input int kind);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          i;
        prog_len = 8 + int'(stim_random() % (MAX_LEN - 8));
        for (i = 0; i < prog_len - 1; i++) begin
            r   = stim_random();
            f3  = r[14:12];
            f7  = (r[30] && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
            imm = r[31:20];
            if (f3 == 3'd1) begin
                imm = {7'h00, r[24:20]};
            end else if (f3 == 3'd5) begin
                imm = {1'b0, r[30], 5'b0, r[24:20]};
            end
            case (kind)
                0:       prog[i] = {f7, r[24:20], r[19:15], f3, r[11:7], OP_OP};
                1:       prog[i] = {imm, r[19:15], f3, r[11:7], OP_IMM};
                default: prog[i] = {r[31:12], r[11:7], r[0] ? OP_LUI : OP_AUIPC};
            endcase
        end
        prog[prog_len-1] = EBREAK;
    endtask

    task automatic run_program(input int kind);
        logic [31:0] r;
        make_program(kind);
        r = stim_random();
        start_pc = stim_random();
        start_pc[1:0] = 2'b00;
        // keep the program inside the word address range
        start_pc[MEM_ADDR_BITS+1:2] = r % ((1 << MEM_ADDR_BITS) - MAX_LEN);
        fetch_idx       = 0;
        start_address_i = start_pc;
        start_i         = 1'b1;
        wait_cycle();
        start_i         = 1'b0;
        while (!paused_o) begin
            wait_cycle();
        end
        if (fetch_idx != prog_len) begin
            $display("core paused after %0d of %0d fetches", fetch_idx, prog_len);
            stop_with_failure();
        end
        run_model();
        compare_all_regs();
    endtask

    // ----------------------------------------------------------------------
    // memory model, 1 to 4 cycles of latency
    // ----------------------------------------------------------------------
    always begin
        wait_cycle();
        if (!rst_i && mem_read_en_o) begin
            if (fetch_idx >= prog_len) begin
                $display("memory read requested after EBREAK without a new start");
                stop_with_failure();
            end
            check_pc("mem_addr_o",
                     reindeer_pkg::pc_t'(start_pc[MEM_ADDR_BITS+1:2]) +
                     reindeer_pkg::pc_t'(fetch_idx),
                     reindeer_pkg::pc_t'(mem_addr_o));
            mem_rng = xorshift32(mem_rng);
            repeat (mem_rng[1:0] + 3'd1) @(posedge clk);
            #1;
            mem_read_ack_i  = 1'b1;
            mem_read_data_i = prog[fetch_idx];
            wait_cycle();
            mem_read_ack_i  = 1'b0;
            mem_read_data_i = '0;
            check_pc("peek_pc_o", start_pc + reindeer_pkg::pc_t'(4 * fetch_idx), peek_pc_o);
            check_inst("peek_ir_o", prog[fetch_idx], peek_ir_o);
            fetch_idx++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    initial begin
        int                  r;
        int                  p;
        reindeer_pkg::word_t value;
        rst_i                = 1'b1;
        start_i              = 1'b0;
        start_address_i      = '0;
        mem_read_data_i      = '0;
        mem_read_ack_i       = 1'b0;
        ocd_reg_we_i         = 1'b0;
        ocd_reg_write_addr_i = '0;
        ocd_reg_write_data_i = '0;
        ocd_reg_read_addr_i  = '0;
        model_regs[0]        = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // debugger writes while paused after reset
        for (r = 1; r < 32; r++) begin
            value         = stim_random();
            model_regs[r] = value;
            reg_write(reindeer_pkg::reg_addr_t'(r), value);
        end
        reg_write(5'd0, stim_random());
        compare_all_regs();

        for (p = 0; p < N_PROGS; p++) begin
            run_program(p % 3);
        end

        if (uut.assertions_i.failures != 0) begin
            $display("%0d protocol assertion failures", uut.assertions_i.failures);
            stop_with_failure();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* filelist.f */
verilog/reindeer_pkg.sv
verilog/reindeer_fetch.sv
verilog/reindeer_decode.sv
verilog/reindeer_reg_file.sv
verilog/reindeer_execute.sv
verilog/reindeer_controller.sv
verilog/reindeer_core.sv
verification/reindeer_assertions.sv
verification/reindeer_tb.sv

/* Bender.yml */
package:
  name: reindeer_core

sources:
  - verilog/reindeer_pkg.sv
  - verilog/reindeer_fetch.sv
  - verilog/reindeer_decode.sv
  - verilog/reindeer_reg_file.sv
  - verilog/reindeer_execute.sv
  - verilog/reindeer_controller.sv
  - verilog/reindeer_core.sv
  - target: test
    files:
      - verification/reindeer_assertions.sv
      - verification/reindeer_tb.sv
